// File: rtl/ql_ipc_pkg.sv
package ql_ipc_pkg;

  // ======================================================================
  // Host link and reply path
  // ======================================================================

  // One host strobe carries one bit
  typedef struct packed {
    logic valid;
    logic data;
  } ipc_wr_t;

  typedef struct packed {
    logic        valid;
    logic [15:0] word;   // MSB goes out first
    logic [4:0]  count;  // Bits in this reply
  } reply_load_t;

  // ======================================================================
  // Sound parameters and beep control
  // ======================================================================

  // Field view of the 64-bit set-sound word
  typedef struct packed {
    logic [7:0]  pitch;
    logic [23:0] unused_hi;
    logic [7:0]  dur_lo;
    logic        ignored;
    logic [6:0]  dur_hi;
    logic [15:0] unused_lo;
  } sound_fields_t;

  typedef union packed {
    logic [63:0]   raw;     // Shift register view
    sound_fields_t fields;
  } sound_param_u;

  typedef struct packed {
    logic        valid;
    logic        kill;      // Stop the current beep
    logic [9:0]  period;    // 256 minus pitch
    logic [14:0] duration;  // Zero runs until killed
  } beep_req_t;

  // ======================================================================
  // Keyboard
  // ======================================================================

  typedef struct packed {
    logic [2:0] row;
    logic [2:0] col;
    logic       shift;
    logic       ctrl;
    logic       alt;
  } key_info_t;

  // Byte r is row r, bits 56..58 are shift, ctrl, alt
  typedef logic [63:0] kbd_matrix_t;

  // IPC command nibbles
  localparam logic [3:0] cmd_status     = 4'd1;
  localparam logic [3:0] cmd_read_key   = 4'd8;
  localparam logic [3:0] cmd_key_row    = 4'd9;
  localparam logic [3:0] cmd_set_sound  = 4'd10;
  localparam logic [3:0] cmd_kill_sound = 4'd11;

endpackage

// File: rtl/keyboard_encoder.sv
`timescale 1ns/1ps

module keyboard_encoder (
  input  ql_ipc_pkg::kbd_matrix_t i_kbd_matrix,
  output ql_ipc_pkg::key_info_t   o_key
);

  logic [2:0] row_sel;
  logic [2:0] col_sel;
  logic [7:0] row_byte;
  logic [7:0] col_mask;
  logic       mod_down;
  logic       other_down;

  // Lowest row with any key down, row 7 if none
  always_comb begin
    row_sel = 3'd7;
    for (int r = 6; r >= 0; r--) begin
      if (i_kbd_matrix[r*8 +: 8] != 8'h00) begin
        row_sel = 3'(r);
      end
    end
  end

  assign mod_down   = |i_kbd_matrix[58:56];
  assign other_down = |i_kbd_matrix[63:59];

  // Hide the modifiers when a real key shares row 7 with them
  assign col_mask = (row_sel == 3'd7 && mod_down && other_down) ? 8'hf8 : 8'hff;
  assign row_byte = i_kbd_matrix[{row_sel, 3'b000} +: 8] & col_mask;

  always_comb begin
    col_sel = 3'd7;  // Default when the byte is empty
    for (int c = 6; c >= 0; c--) begin
      if (row_byte[c]) begin
        col_sel = 3'(c);
      end
    end
  end

  always_comb begin
    o_key.row   = row_sel;
    o_key.col   = col_sel;
    o_key.shift = i_kbd_matrix[56];
    o_key.ctrl  = i_kbd_matrix[57];
    o_key.alt   = i_kbd_matrix[58];
  end

endmodule

// File: rtl/ipc_command_decoder.sv
`timescale 1ns/1ps

module ipc_command_decoder (
  input  logic                     clk_cpu,
  input  logic                     reset,
  input  ql_ipc_pkg::ipc_wr_t      i_ipc,
  input  ql_ipc_pkg::key_info_t    i_key,
  input  logic                     i_key_press,
  input  ql_ipc_pkg::kbd_matrix_t  i_kbd_matrix,
  input  logic                     i_reply_active,
  output ql_ipc_pkg::reply_load_t  o_reply_load,
  output ql_ipc_pkg::beep_req_t    o_beep_req,
  output logic [3:0]               o_last_cmd
);

  // Decoder phases
  localparam logic [1:0] ph_cmd     = 2'd0;
  localparam logic [1:0] ph_key_row = 2'd1;
  localparam logic [1:0] ph_sound   = 2'd2;

  logic [1:0]               phase;
  logic [5:0]               bit_cnt;
  logic                     key_flag;
  logic                     bit_strobe;
  logic [3:0]               nibble;
  logic [3:0]               nib_next;
  ql_ipc_pkg::sound_param_u sound_word;
  ql_ipc_pkg::sound_param_u sound_next;
  logic [7:0]               row_byte;

  function automatic ql_ipc_pkg::reply_load_t make_reply(input logic [15:0] word,
                                                         input logic [4:0]  count);
    ql_ipc_pkg::reply_load_t r;
    r.valid = 1'b1;
    r.word  = word;
    r.count = count;
    return r;
  endfunction

  // Strobes during a reply belong to the shifter
  assign bit_strobe = i_ipc.valid && !i_reply_active;
  assign nib_next   = {nibble[2:0], i_ipc.data};
  assign row_byte   = i_kbd_matrix[{nib_next[2:0], 3'b000} +: 8];

  always_comb begin
    sound_next.raw = {sound_word.raw[62:0], i_ipc.data};
  end

  // Incoming bit shift registers
  always_ff @(posedge clk_cpu) begin
    if (bit_strobe) begin
      nibble <= nib_next;
      if (phase == ph_sound) begin
        sound_word <= sound_next;
      end
    end
  end

  // ======================================================================
  // Command and parameter FSM
  // ======================================================================

  always_ff @(posedge clk_cpu) begin
    if (reset) begin
      phase        <= ph_cmd;
      bit_cnt      <= '0;
      key_flag     <= 1'b0;
      o_last_cmd   <= '0;
      o_reply_load <= '0;
      o_beep_req   <= '0;
    end else begin
      o_reply_load.valid <= 1'b0;  // Single-cycle strobes
      o_beep_req.valid   <= 1'b0;
      if (bit_strobe) begin
        bit_cnt <= bit_cnt + 6'd1;
        case (phase)
          ph_cmd: begin
            if (bit_cnt == 6'd3) begin
              bit_cnt    <= '0;
              o_last_cmd <= nib_next;
              case (nib_next)
                ql_ipc_pkg::cmd_status: begin
                  o_reply_load <= make_reply({7'b0, key_flag, 8'b0}, 5'd8);
                  key_flag     <= 1'b0;
                end
                ql_ipc_pkg::cmd_read_key: begin
                  o_reply_load <= make_reply({4'b0001, 1'b0, i_key.shift, i_key.ctrl,
                                              i_key.alt, 2'b00, ~i_key.row, i_key.col},
                                             5'd16);
                end
                ql_ipc_pkg::cmd_key_row:   phase <= ph_key_row;
                ql_ipc_pkg::cmd_set_sound: phase <= ph_sound;
                ql_ipc_pkg::cmd_kill_sound: begin
                  o_beep_req <= '{valid: 1'b1, kill: 1'b1, period: '0, duration: '0};
                end
                default: ;  // Accepted, no action
              endcase
            end
          end
          ph_key_row: begin
            if (bit_cnt == 6'd3) begin  // Row index complete
              bit_cnt      <= '0;
              phase        <= ph_cmd;
              o_reply_load <= make_reply({row_byte, 8'b0}, 5'd8);
            end
          end
          ph_sound: begin
            if (bit_cnt == 6'd63) begin
              bit_cnt <= '0;
              phase   <= ph_cmd;
              o_beep_req.valid    <= 1'b1;
              o_beep_req.kill     <= 1'b0;
              o_beep_req.period   <= 10'd256 - {2'b00, sound_next.fields.pitch};
              o_beep_req.duration <= {sound_next.fields.dur_hi, sound_next.fields.dur_lo};
            end
          end
          default: begin
            phase   <= ph_cmd;
            bit_cnt <= '0;
          end
        endcase
      end
      // A new key press wins over the status clear
      if (i_key_press) begin
        key_flag <= 1'b1;
      end
    end
  end

endmodule

// File: rtl/ipc_reply_shifter.sv
`timescale 1ns/1ps

module ipc_reply_shifter (
  input  logic                    clk_cpu,
  input  logic                    reset,
  input  ql_ipc_pkg::ipc_wr_t     i_ipc,
  input  ql_ipc_pkg::reply_load_t i_load,
  output logic                    o_reply_bit,
  output logic                    o_reply_active
);

  logic [15:0] shift_word;
  logic [4:0]  bits_left;

  always_ff @(posedge clk_cpu) begin
    if (reset) begin
      shift_word <= '0;
      bits_left  <= '0;
    end else if (i_load.valid) begin  // New reply replaces the old one
      shift_word <= i_load.word;
      bits_left  <= i_load.count;
    end else if (i_ipc.valid && o_reply_active) begin
      shift_word <= {shift_word[14:0], 1'b0};
      bits_left  <= bits_left - 5'd1;
    end
  end

  // Host samples the MSB before each read strobe
  assign o_reply_bit    = shift_word[15];
  assign o_reply_active = (bits_left != 5'd0);

endmodule

// File: rtl/beep_generator.sv
`timescale 1ns/1ps

module beep_generator #(
  parameter int p_unit_cycles = 1944,
  parameter int p_tone_div    = 8
) (
  input  logic                  clk_cpu,
  input  logic                  reset,
  input  ql_ipc_pkg::beep_req_t i_req,
  output logic                  o_beep_active,
  output logic                  o_audio
);

  localparam int c_unit_w = $clog2(p_unit_cycles + 1);
  localparam int c_tone_w = $clog2(256 * p_tone_div + 1);

  logic [c_unit_w-1:0] unit_cnt;
  logic [14:0]         dur_left;
  logic                endless;
  logic [c_tone_w-1:0] tone_cnt;
  logic [c_tone_w-1:0] tone_last;

  // Half-period length of the square wave
  always_ff @(posedge clk_cpu) begin
    if (i_req.valid && !i_req.kill) begin
      tone_last <= c_tone_w'(i_req.period * p_tone_div - 1);
    end
  end

  always_ff @(posedge clk_cpu) begin
    if (reset) begin
      o_beep_active <= 1'b0;
      o_audio       <= 1'b0;
      unit_cnt      <= '0;
      dur_left      <= '0;
      endless       <= 1'b0;
      tone_cnt      <= '0;
    end else if (i_req.valid) begin
      o_beep_active <= !i_req.kill;
      o_audio       <= 1'b0;
      unit_cnt      <= '0;
      tone_cnt      <= '0;
      dur_left      <= i_req.duration;
      endless       <= (i_req.duration == 15'd0);
    end else if (o_beep_active) begin
      // ==================================================================
      // Tone divider
      // ==================================================================
      if (tone_cnt == tone_last) begin
        tone_cnt <= '0;
        o_audio  <= ~o_audio;
      end else begin
        tone_cnt <= tone_cnt + 1'b1;
      end

      // ==================================================================
      // Duration in units of p_unit_cycles
      // ==================================================================
      if (!endless) begin
        if (unit_cnt == c_unit_w'(p_unit_cycles - 1)) begin
          unit_cnt <= '0;
          if (dur_left == 15'd0) begin  // Last unit done
            o_beep_active <= 1'b0;
            o_audio       <= 1'b0;
          end else begin
            dur_left <= dur_left - 15'd1;
          end
        end else begin
          unit_cnt <= unit_cnt + 1'b1;
        end
      end
    end
  end

endmodule

// File: rtl/ql_ipc_top.sv
`timescale 1ns/1ps

module ql_ipc_top #(
  parameter int p_unit_cycles = 1944,  // About 70 us at 27 MHz
  parameter int p_tone_div    = 8
) (
  input  logic                    clk_cpu,
  input  logic                    reset,
  input  ql_ipc_pkg::ipc_wr_t     i_ipc,
  input  logic                    i_key_press,
  input  ql_ipc_pkg::kbd_matrix_t i_kbd_matrix,
  output logic                    o_reply_bit,
  output logic                    o_reply_active,
  output logic                    o_beep_active,
  output logic                    o_audio,
  output logic [3:0]              o_last_cmd
);

  ql_ipc_pkg::key_info_t   key;
  ql_ipc_pkg::reply_load_t reply_load;
  ql_ipc_pkg::beep_req_t   beep_req;

  // Matrix to key code, combinational
  keyboard_encoder u_keyboard_encoder (
    .i_kbd_matrix (i_kbd_matrix),
    .o_key        (key)
  );

  ipc_command_decoder u_ipc_command_decoder (
    .clk_cpu        (clk_cpu),
    .reset          (reset),
    .i_ipc          (i_ipc),
    .i_key          (key),
    .i_key_press    (i_key_press),
    .i_kbd_matrix   (i_kbd_matrix),
    .i_reply_active (o_reply_active),
    .o_reply_load   (reply_load),
    .o_beep_req     (beep_req),
    .o_last_cmd     (o_last_cmd)
  );

  // Host reads replies back through the same strobe
  ipc_reply_shifter u_ipc_reply_shifter (
    .clk_cpu        (clk_cpu),
    .reset          (reset),
    .i_ipc          (i_ipc),
    .i_load         (reply_load),
    .o_reply_bit    (o_reply_bit),
    .o_reply_active (o_reply_active)
  );

  beep_generator #(
    .p_unit_cycles (p_unit_cycles),
    .p_tone_div    (p_tone_div)
  ) u_beep_generator (
    .clk_cpu       (clk_cpu),
    .reset         (reset),
    .i_req         (beep_req),
    .o_beep_active (o_beep_active),
    .o_audio       (o_audio)
  );

endmodule

// File: tb/ql_ipc_checker.sv
`timescale 1ns/1ps

module ql_ipc_checker (
  input logic       i_reply_bit,
  input logic       i_reply_active,
  input logic       i_beep_active,
  input logic       i_audio,
  input logic [3:0] i_last_cmd
);

  int n_checks = 0;
  int n_errors = 0;

  task automatic compare_value(input string name, input int exp, input int act,
                               input int tol);
    n_checks++;
    if (act < exp - tol || act > exp + tol) begin
      n_errors++;
      $display("[ERROR] %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  // Reply bit as the host sees it before a read strobe
  task automatic check_reply_bit(input string name, input logic exp);
    compare_value({name, " reply_bit"}, int'(exp), int'(i_reply_bit), 0);
  endtask

  task automatic check_last_cmd(input string name, input logic [3:0] exp);
    compare_value({name, " last_cmd"}, int'(exp), int'(i_last_cmd), 0);
  endtask

  task automatic check_reply_active(input string name, input logic exp);
    compare_value({name, " reply_active"}, int'(exp), int'(i_reply_active), 0);
  endtask

  task automatic check_beep(input string name, input logic exp_active);
    compare_value({name, " beep_active"}, int'(exp_active), int'(i_beep_active), 0);
    if (!exp_active) compare_value({name, " audio"}, 0, int'(i_audio), 0);
  endtask

  task automatic report_timeout(input string name, input string what);
    n_errors++;
    $display("Timeout in test %s while waiting for %s", name, what);
  endtask

endmodule

// File: tb/ql_ipc_asserts.sv
`timescale 1ns/1ps

module ql_ipc_asserts (
  input logic                clk_cpu,
  input logic                reset,
  input ql_ipc_pkg::ipc_wr_t i_ipc,
  input logic                o_reply_active,
  input logic                o_beep_active,
  input logic                o_audio
);

  // Silence outside a beep
  audio_quiet: assert property (@(posedge clk_cpu) disable iff (reset)
    !o_beep_active |-> !o_audio)
    else $error("audio high while no beep is active");

  // Reply ends only after a read strobe
  reply_end: assert property (@(posedge clk_cpu) disable iff (reset)
    $fell(o_reply_active) |-> $past(i_ipc.valid))
    else $error("reply_active fell without a strobe");

endmodule

bind ql_ipc_top ql_ipc_asserts u_asserts (.*);

// File: tb/ql_ipc_tb.sv
`timescale 1ns/1ps

module ql_ipc_tb;

  localparam int c_unit    = 8;
  localparam int c_div     = 2;
  localparam int c_timeout = 2000;

  typedef struct {
    string       name;
    logic [3:0]  cmd;
    int          mat_mode;   // Matrix from 0 fixed, 1 random or 2 random row 7
    logic [63:0] matrix;
    logic        key_press;
    logic [15:0] exp_word;   // Ignored for read key and key row
    int          exp_len;
    int          exp_beep;   // Cycles high where 0 means none and -1 endless
    logic [7:0]  pitch;
    logic [14:0] dur;
  } test_t;

  logic                    clk_cpu = 1'b0;
  logic                    reset;
  ql_ipc_pkg::ipc_wr_t     ipc;
  logic                    key_press;
  ql_ipc_pkg::kbd_matrix_t kbd_matrix;
  logic                    reply_bit;
  logic                    reply_active;
  logic                    beep_active;
  logic                    audio;
  logic [3:0]              last_cmd;
  logic [31:0]             lfsr_state = 32'd93696;
  test_t                   tests[$];

  always #2 clk_cpu = ~clk_cpu;

  ql_ipc_top #(
    .p_unit_cycles (c_unit),
    .p_tone_div    (c_div)
  ) dut (
    .clk_cpu        (clk_cpu),
    .reset          (reset),
    .i_ipc          (ipc),
    .i_key_press    (key_press),
    .i_kbd_matrix   (kbd_matrix),
    .o_reply_bit    (reply_bit),
    .o_reply_active (reply_active),
    .o_beep_active  (beep_active),
    .o_audio        (audio),
    .o_last_cmd     (last_cmd)
  );

  ql_ipc_checker chk (
    .i_reply_bit    (reply_bit),
    .i_reply_active (reply_active),
    .i_beep_active  (beep_active),
    .i_audio        (audio),
    .i_last_cmd     (last_cmd)
  );

  // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
  function automatic logic [63:0] rand_bits(input int n);
    logic        fb;
    logic [63:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      val = {val[62:0], fb};
    end
    return val;
  endfunction

  task automatic add_test(input string name, input logic [3:0] cmd, input int mat_mode,
                          input logic [63:0] matrix, input logic press,
                          input logic [15:0] exp_word, input int exp_len,
                          input int exp_beep, input logic [7:0] pitch,
                          input logic [14:0] dur);
    test_t t;
    t = '{name, cmd, mat_mode, matrix, press, exp_word, exp_len, exp_beep, pitch, dur};
    tests.push_back(t);
  endtask

  // Single strobe without the trailing gap
  task automatic pulse_bit(input logic b);
    @(posedge clk_cpu);
    #1 ipc = '{valid: 1'b1, data: b};
    @(posedge clk_cpu);
    #1 ipc = '0;
  endtask

  task automatic send_bit(input logic b);
    pulse_bit(b);
    repeat (3) @(posedge clk_cpu);
    #1;
  endtask

  task automatic send_bits(input logic [63:0] val, input int n);
    for (int i = n - 1; i >= 0; i--) begin
      send_bit(val[i]);
    end
  endtask

  // Key code of the lowest active row and column with the row 7 mask
  function automatic logic [15:0] model_read_key(input logic [63:0] m);
    int         row;
    int         col;
    logic [7:0] b;
    row = 7;
    col = 7;
    for (int r = 6; r >= 0; r--) begin
      if (m[r*8 +: 8] != 8'h00) row = r;
    end
    b = m[row*8 +: 8];
    if (row == 7 && (|m[58:56]) && (|m[63:59])) b = b & 8'hf8;
    for (int c = 6; c >= 0; c--) begin
      if (b[c]) col = c;
    end
    return {4'b0001, 1'b0, m[56], m[57], m[58], 2'b00, ~3'(row), 3'(col)};
  endfunction

  // Polls reply_active or beep_active until it goes high
  task automatic wait_high(input string name, input string what, input logic on_reply);
    int   n;
    logic seen;
    n = 0;
    seen = on_reply ? reply_active : beep_active;
    while (seen !== 1'b1 && n < c_timeout) begin
      @(posedge clk_cpu);
      #1;
      n++;
      seen = on_reply ? reply_active : beep_active;
    end
    if (seen !== 1'b1) chk.report_timeout(name, what);
  endtask

  task automatic measure_beep(input string name, input int exp_cycles, input int period);
    int   cycles;
    int   t1;
    int   t2;
    logic last_audio;
    cycles = 0;
    t1 = -1;
    t2 = -1;
    last_audio = 1'b0;
    wait_high(name, "beep start", 1'b0);
    while (beep_active && cycles < c_timeout) begin
      @(posedge clk_cpu);
      #1;
      cycles++;
      if (audio !== last_audio) begin
        if (t1 < 0) t1 = cycles;
        else if (t2 < 0) t2 = cycles;
        last_audio = audio;
      end
    end
    if (beep_active) chk.report_timeout(name, "beep end");
    chk.compare_value({name, " length"}, exp_cycles, cycles, 2);
    chk.compare_value({name, " tone"}, period * c_div, t2 - t1, 0);
  endtask

  task automatic run_test(input test_t t);
    logic [63:0] m;
    logic [63:0] r;
    logic [15:0] w;
    m = t.matrix;
    w = t.exp_word;
    if (t.mat_mode == 1) m = rand_bits(64);
    if (t.mat_mode == 2) begin
      r = rand_bits(8);
      m = {r[7:0], 56'h0};
    end
    @(posedge clk_cpu);
    #1 kbd_matrix = m;
    if (t.key_press) begin
      @(posedge clk_cpu);
      #1 key_press = 1'b1;
      @(posedge clk_cpu);
      #1 key_press = 1'b0;
    end
    if (t.cmd == ql_ipc_pkg::cmd_read_key) w = model_read_key(m);
    send_bits({60'h0, t.cmd}, 4);
    chk.check_last_cmd(t.name, t.cmd);
    if (t.cmd == ql_ipc_pkg::cmd_key_row) begin
      r = rand_bits(3);
      w = {m[r[2:0]*8 +: 8], 8'h00};
      send_bits(r, 4);
    end
    if (t.cmd == ql_ipc_pkg::cmd_set_sound) begin
      r = {t.pitch, 24'h0, t.dur[7:0], 1'b0, t.dur[14:8], 16'h0};
      send_bits(r >> 1, 63);
      pulse_bit(r[0]);
    end
    if (t.exp_beep > 0) begin
      measure_beep(t.name, t.exp_beep, 256 - int'(t.pitch));
    end else if (t.exp_beep < 0) begin
      wait_high(t.name, "beep start", 1'b0);
      repeat (100) @(posedge clk_cpu);
      #1 chk.check_beep(t.name, 1'b1);
    end else begin
      chk.check_beep(t.name, 1'b0);
    end
    if (t.exp_len > 0) begin
      wait_high(t.name, "reply", 1'b1);
      for (int i = 0; i < t.exp_len; i++) begin
        chk.check_reply_active(t.name, 1'b1);
        chk.check_reply_bit(t.name, w[15-i]);  // Sampled before the read strobe
        send_bit(1'b0);
      end
    end
    chk.check_reply_active(t.name, 1'b0);
  endtask

  initial begin
    reset      = 1'b1;
    ipc        = '0;
    key_press  = 1'b0;
    kbd_matrix = '0;
    repeat (5) @(posedge clk_cpu);
    #1 reset = 1'b0;
    chk.check_last_cmd("after_reset", 4'd0);
    chk.check_reply_active("after_reset", 1'b0);
    chk.check_reply_bit("after_reset", 1'b0);
    chk.check_beep("after_reset", 1'b0);

    add_test("status_idle", 4'd1, 0, 64'h0, 1'b0, 16'h0000, 8, 0, 8'd0, 15'd0);
    add_test("status_press", 4'd1, 0, 64'h0, 1'b1, 16'h0100, 8, 0, 8'd0, 15'd0);
    add_test("status_again", 4'd1, 0, 64'h0, 1'b0, 16'h0000, 8, 0, 8'd0, 15'd0);
    for (int i = 0; i < 4; i++) begin
      add_test("read_key_rand", 4'd8, 1, 64'h0, 1'b0, 16'h0, 16, 0, 8'd0, 15'd0);
    end
    add_test("read_key_row7", 4'd8, 2, 64'h0, 1'b0, 16'h0, 16, 0, 8'd0, 15'd0);
    add_test("read_key_mods", 4'd8, 0, 64'h0500_0000_0000_0000, 1'b0, 16'h0, 16, 0,
             8'd0, 15'd0);
    add_test("read_key_mask", 4'd8, 0, 64'h2300_0000_0000_0000, 1'b0, 16'h0, 16, 0,
             8'd0, 15'd0);
    for (int i = 0; i < 3; i++) begin
      add_test("key_row_rand", 4'd9, 1, 64'h0, 1'b0, 16'h0, 8, 0, 8'd0, 15'd0);
    end
    add_test("sound_short", 4'd10, 0, 64'h0, 1'b0, 16'h0, 0, 6 * c_unit, 8'd250, 15'd5);
    add_test("sound_long", 4'd10, 0, 64'h0, 1'b0, 16'h0, 0, 10 * c_unit, 8'd244, 15'd9);
    add_test("sound_endless", 4'd10, 0, 64'h0, 1'b0, 16'h0, 0, -1, 8'd240, 15'd0);
    add_test("kill_sound", 4'd11, 0, 64'h0, 1'b0, 16'h0, 0, 0, 8'd0, 15'd0);
    for (int c = 0; c < 16; c++) begin
      if (!(c == 1 || (c >= 8 && c <= 11))) begin
        add_test("unused_cmd", 4'(c), 0, 64'h0, 1'b0, 16'h0, 0, 0, 8'd0, 15'd0);
      end
    end

    foreach (tests[i]) run_test(tests[i]);

    $display("Checks run: %0d, errors: %0d", chk.n_checks, chk.n_errors);
    if (chk.n_errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: ql_ipc_top.f
rtl/ql_ipc_pkg.sv
rtl/keyboard_encoder.sv
rtl/ipc_command_decoder.sv
rtl/ipc_reply_shifter.sv
rtl/beep_generator.sv
rtl/ql_ipc_top.sv
tb/ql_ipc_checker.sv
tb/ql_ipc_asserts.sv
tb/ql_ipc_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= ql_ipc_tb
FILELIST  ?= ql_ipc_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(wildcard rtl/*.sv tb/*.sv)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "All checks passed"

clean:
	rm -rf $(BUILD_DIR)
